// ==== build.f ====
+incdir+verilog
verilog/dac_pkg.sv
verilog/sclk_gen.sv
verilog/word_latch.sv
verilog/frame_sequencer.sv
verilog/quad_dac_spi.sv
test/tb_dac_slave.sv
test/tb_quad_dac_spi.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -j 0 \
    --top-module tb_quad_dac_spi \
    -f build.f \
    -o sim_quad_dac_spi

./obj_dir/sim_quad_dac_spi

// ==== test/tb_quad_dac_spi.sv ====
`include "dac_cfg.svh"

module tb_quad_dac_spi
    import dac_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int          QUIET_CYCLES  = 40;    // longer than one sclk period
    localparam int          SILENT_CYCLES = 800;   // about three frames
    localparam int          WAIT_LIMIT    = 20000;
    localparam logic [31:0] LCG_MUL       = 32'd1664525;
    localparam logic [31:0] LCG_INC       = 32'd1013904223;

    logic                PMD_clk;
    logic                arst_n;
    stream_word_t        ch_data [`NUM_DAC];
    logic [`NUM_DAC-1:0] ch_valid;
    stream_word_t        cfg_data;
    logic                cfg_valid;
    logic                cfg_mode;
    chan_sel_t           cfg_chan;
    logic                cfg_send;
    logic                sclk;
    logic                sync_n;
    logic [`NUM_DAC-1:0] sdin;
    stream_word_t        mon_word [`NUM_DAC];
    logic                ready;
    int                  frame_count;
    int                  frame_bits;
    dac_word_t           frame_word [`NUM_DAC];

    logic [31:0]         rng_state;
    dac_word_t           expect_word [`NUM_DAC];  // latest command per channel
    logic                check_prefix;            // stream frames only

    quad_dac_spi dut0
    (
        .PMD_clk   (PMD_clk),
        .arst_n    (arst_n),
        .ch_data   (ch_data),
        .ch_valid  (ch_valid),
        .cfg_data  (cfg_data),
        .cfg_valid (cfg_valid),
        .cfg_mode  (cfg_mode),
        .cfg_chan  (cfg_chan),
        .cfg_send  (cfg_send),
        .sclk      (sclk),
        .sync_n    (sync_n),
        .sdin      (sdin),
        .mon0      (mon_word[0]),
        .mon1      (mon_word[1]),
        .mon2      (mon_word[2]),
        .mon3      (mon_word[3]),
        .ready     (ready)
    );

    tb_dac_slave slave0
    (
        .sclk        (sclk),
        .sync_n      (sync_n),
        .sdin        (sdin),
        .frame_count (frame_count),
        .frame_bits  (frame_bits),
        .frame_word  (frame_word)
    );

    initial
    begin
        PMD_clk = 1'b0;
        forever #20 PMD_clk = ~PMD_clk;
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next();
        rng_state = rng_state * LCG_MUL + LCG_INC;
        return rng_state;
    endfunction

    // code on top, prefix in the low nibble
    function automatic stream_word_t mon_expected(input dac_word_t w);
        return {w[19:0], 8'h00, w[23:20]};
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected)
            abort_run($sformatf("MISMATCH at %0t: %s, got %h, expected %h",
                                $time, what, actual, expected));
    endtask

    task automatic wait_idle();
        int cycles;
        int quiet;
        cycles = 0;
        quiet  = 0;
        while (quiet < QUIET_CYCLES)
        begin
            @(negedge PMD_clk);
            cycles++;
            quiet = (ready && sync_n) ? quiet + 1 : 0;
            if (cycles > WAIT_LIMIT)
                abort_run("timeout: the DUT did not return to idle");
        end
    endtask

    task automatic wait_frame(input int count_before);
        int cycles;
        cycles = 0;
        while (frame_count == count_before)
        begin
            @(negedge PMD_clk);
            cycles++;
            if (cycles > WAIT_LIMIT)
                abort_run("timeout: no frame appeared on the serial bus");
        end
    endtask

    task automatic expect_silence(input string what);
        int count_before;
        count_before = frame_count;
        for (int i = 0; i < SILENT_CYCLES; i++)
        begin
            @(negedge PMD_clk);
            check_equal(32'(sync_n), 32'd1, {what, ", sync_n"});
        end
        check_equal(32'(frame_count), 32'(count_before), {what, ", frame count"});
    endtask

    task automatic stream_write(input logic [`NUM_DAC-1:0] mask);
        @(negedge PMD_clk);
        for (int i = 0; i < `NUM_DAC; i++)
        begin
            ch_data[i] = lcg_next();
            if (mask[i])
                expect_word[i] = {`DAC_WRITE_PREFIX,
                                  ch_data[i][`STREAM_WIDTH-1 -: `DAC_DATA_WIDTH]};
        end
        ch_valid = mask;
        @(negedge PMD_clk);
        ch_valid = '0;
    endtask

    // same code again, only the dropped low bits change
    task automatic rewrite_same();
        logic [31:0] r;
        @(negedge PMD_clk);
        for (int i = 0; i < `NUM_DAC; i++)
        begin
            r = lcg_next();
            ch_data[i] = {expect_word[i][`DAC_DATA_WIDTH-1:0],
                          r[`STREAM_WIDTH-`DAC_DATA_WIDTH-1:0]};
        end
        ch_valid = '1;
        @(negedge PMD_clk);
        ch_valid = '0;
    endtask

    task automatic cfg_write();
        logic [31:0] r;
        @(negedge PMD_clk);
        r         = lcg_next();
        cfg_chan  = r[31:30];
        cfg_data  = lcg_next();
        cfg_valid = 1'b1;
        expect_word[cfg_chan] = cfg_data[`DAC_WORD_WIDTH-1:0];  // raw command
        @(negedge PMD_clk);
        cfg_valid = 1'b0;
    endtask

    task automatic check_last_frame(input string what);
        for (int i = 0; i < `NUM_DAC; i++)
        begin
            check_equal(32'(frame_word[i]), 32'(expect_word[i]),
                        $sformatf("%s, line %0d", what, i));
            check_equal(mon_word[i], mon_expected(expect_word[i]),
                        $sformatf("%s, mon%0d", what, i));
        end
    endtask

    // every captured frame, length, prefix and monitors
    always @(frame_count)
    begin
        if (frame_count != 0)
        begin
            check_equal(32'(frame_bits), 32'(`DAC_WORD_WIDTH), "frame length in bits");
            for (int i = 0; i < `NUM_DAC; i++)
            begin
                if (check_prefix)
                    check_equal(32'(frame_word[i][23:20]), 32'(`DAC_WRITE_PREFIX),
                                $sformatf("command prefix on line %0d", i));
                check_equal(mon_word[i], mon_expected(frame_word[i]),
                            $sformatf("mon%0d after frame", i));
            end
        end
    end

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    initial
    begin
        logic [31:0] r;
        int          count_before;

        rng_state    = 32'd30697;
        check_prefix = 1'b0;
        arst_n       = 1'b0;
        ch_valid     = '0;
        cfg_data     = '0;
        cfg_valid    = 1'b0;
        cfg_mode     = 1'b0;
        cfg_chan     = '0;
        cfg_send     = 1'b0;
        for (int i = 0; i < `NUM_DAC; i++)
        begin
            ch_data[i]     = '0;
            expect_word[i] = '0;
        end
        repeat (3) @(posedge PMD_clk);
        @(negedge PMD_clk);
        check_equal(32'(ready), 32'd1, "ready in reset");
        check_equal(32'(sync_n), 32'd1, "sync_n in reset");
        check_equal(32'(sclk), 32'd0, "sclk in reset");
        check_equal(32'(sdin), 32'd0, "sdin in reset");
        arst_n = 1'b1;
        expect_silence("idle after reset");

        // stream mode, random bursts with random gaps
        check_prefix = 1'b1;
        stream_write('1);
        for (int n = 0; n < 40; n++)
        begin
            r = lcg_next();
            stream_write(r[31:28]);
            repeat (r[15:8]) @(negedge PMD_clk);
        end
        wait_idle();
        check_last_frame("last stream frame");
        rewrite_same();
        expect_silence("rewrite of the sent value");
        check_prefix = 1'b0;

        // config mode, one frame per rising send level
        @(negedge PMD_clk);
        cfg_mode = 1'b1;
        for (int round = 0; round < 2; round++)
        begin
            repeat (6) cfg_write();
            expect_silence("config writes before send");
            count_before = frame_count;
            @(negedge PMD_clk);
            cfg_send = 1'b1;
            wait_frame(count_before);
            wait_idle();
            check_equal(32'(frame_count), 32'(count_before + 1), "frames per send edge");
            check_last_frame("config frame");
            cfg_write();  // pending until send drops and rises again
            expect_silence("send level held high");
            @(negedge PMD_clk);
            cfg_send = 1'b0;
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== test/tb_dac_slave.sv ====
`include "dac_cfg.svh"

module tb_dac_slave
    import dac_pkg::*;
(
    input  logic                sclk,
    input  logic                sync_n,
    input  logic [`NUM_DAC-1:0] sdin,
    output int                  frame_count,  // completed frames
    output int                  frame_bits,   // falling edges seen in the last frame
    output dac_word_t           frame_word [`NUM_DAC]
);

    timeunit 1ns;
    timeprecision 1ps;

    dac_word_t shift_reg [`NUM_DAC];
    int        bit_cnt;

    //////////////////////////////////////////////////
    // dac input shift registers
    //////////////////////////////////////////////////

    // samples every data line on falling sclk while sync is low
    initial
    begin
        frame_count = 0;
        frame_bits  = 0;
        bit_cnt     = 0;
        for (int i = 0; i < `NUM_DAC; i++)
        begin
            shift_reg[i]  = '0;
            frame_word[i] = '0;
        end
        forever
        begin
            @(negedge sclk or posedge sync_n);
            if (sync_n === 1'b0)
            begin
                for (int i = 0; i < `NUM_DAC; i++)
                begin
                    shift_reg[i] = {shift_reg[i][`DAC_WORD_WIDTH-2:0], sdin[i]};
                end
                bit_cnt++;
            end
            else if ((sync_n === 1'b1) && (bit_cnt != 0))
            begin
                // publish the words before the count moves
                for (int i = 0; i < `NUM_DAC; i++)
                begin
                    frame_word[i] = shift_reg[i];
                end
                frame_bits  = bit_cnt;
                bit_cnt     = 0;
                frame_count = frame_count + 1;
            end
        end
    end

endmodule

// ==== verilog/quad_dac_spi.sv ====
`include "dac_cfg.svh"

module quad_dac_spi
    import dac_pkg::*;
(
    input  logic                 PMD_clk,
    input  logic                 arst_n,

    // stream inputs
    input  stream_word_t         ch_data [`NUM_DAC],
    input  logic [`NUM_DAC-1:0]  ch_valid,

    // configuration inputs
    input  stream_word_t         cfg_data,
    input  logic                 cfg_valid,
    input  logic                 cfg_mode,
    input  chan_sel_t            cfg_chan,
    input  logic                 cfg_send,

    // serial bus
    output logic                 sclk,
    output logic                 sync_n,
    output logic [`NUM_DAC-1:0]  sdin,

    // last sent words
    output stream_word_t         mon0,
    output stream_word_t         mon1,
    output stream_word_t         mon2,
    output stream_word_t         mon3,

    output logic                 ready
);

    logic      rise_stb;
    logic      fall_stb;
    dac_word_t hold_word   [`NUM_DAC];
    dac_word_t shadow_word [`NUM_DAC];

    //////////////////////////////////////////////////
    // monitor packing
    //////////////////////////////////////////////////

    // code in the top bits, prefix in the bottom nibble
    function automatic stream_word_t pack_mon(input dac_word_t w);
        dac_data_t code;
        code = w[`DAC_DATA_WIDTH-1:0];
        return {code, {(`STREAM_WIDTH - `DAC_WORD_WIDTH){1'b0}},
                w[`DAC_WORD_WIDTH-1:`DAC_DATA_WIDTH]};
    endfunction

    assign mon0 = pack_mon(shadow_word[0]);
    assign mon1 = pack_mon(shadow_word[1]);
    assign mon2 = pack_mon(shadow_word[2]);
    assign mon3 = pack_mon(shadow_word[3]);

    //////////////////////////////////////////////////
    // blocks
    //////////////////////////////////////////////////

    sclk_gen u_sclk_gen
    (
        .PMD_clk   (PMD_clk),
        .arst_n    (arst_n),
        .sclk      (sclk),
        .rise_stb  (rise_stb),
        .fall_stb  (fall_stb)
    );

    word_latch u_word_latch
    (
        .PMD_clk   (PMD_clk),
        .arst_n    (arst_n),
        .ch_data   (ch_data),
        .ch_valid  (ch_valid),
        .cfg_mode  (cfg_mode),
        .cfg_data  (cfg_data),
        .cfg_valid (cfg_valid),
        .cfg_chan  (cfg_chan),
        .hold_word (hold_word)
    );

    frame_sequencer u_frame_sequencer
    (
        .PMD_clk     (PMD_clk),
        .arst_n      (arst_n),
        .rise_stb    (rise_stb),
        .fall_stb    (fall_stb),
        .hold_word   (hold_word),
        .cfg_mode    (cfg_mode),
        .cfg_send    (cfg_send),
        .sync_n      (sync_n),
        .sdin        (sdin),
        .shadow_word (shadow_word),
        .ready       (ready)
    );

endmodule

// ==== verilog/frame_sequencer.sv ====
`include "dac_cfg.svh"

module frame_sequencer
    import dac_pkg::*;
(
    input  logic                 PMD_clk,
    input  logic                 arst_n,
    input  logic                 rise_stb,
    input  logic                 fall_stb,
    input  dac_word_t            hold_word [`NUM_DAC],
    input  logic                 cfg_mode,
    input  logic                 cfg_send,
    output logic                 sync_n,
    output logic [`NUM_DAC-1:0]  sdin,
    output dac_word_t            shadow_word [`NUM_DAC],
    output logic                 ready
);

    localparam int BIT_W = $clog2(`DAC_WORD_WIDTH);
    localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(`DAC_WORD_WIDTH - 1);

    frame_state_t     state;
    logic             sync_int;     // frame sync before the output register
    logic             cfg_armed;    // one frame per cfg_send pulse
    logic [BIT_W-1:0] bit_cnt;      // index of the bit on the lines
    logic             word_diff;
    logic             start_frame;

    //////////////////////////////////////////////////
    // frame start decision
    //////////////////////////////////////////////////

    always_comb
    begin
        word_diff = 1'b0;
        for (int i = 0; i < `NUM_DAC; i++)
        begin
            if (hold_word[i] != shadow_word[i])
            begin
                word_diff = 1'b1;
            end
        end
    end

    // stream mode sends on any change, config mode waits for a send edge
    assign start_frame = word_diff & (~cfg_mode | (cfg_send & ~cfg_armed));

    //////////////////////////////////////////////////
    // state machine, advances on falling sclk
    //////////////////////////////////////////////////

    always_ff @(posedge PMD_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state     <= IDLE;
            sync_int  <= 1'b1;
            cfg_armed <= 1'b0;
            bit_cnt   <= '0;
        end
        else if (fall_stb)
        begin
            if (!cfg_send)
            begin
                cfg_armed <= 1'b0;  // send level dropped, rearm
            end

            case (state)
                IDLE:
                begin
                    if (start_frame)
                    begin
                        state <= LOAD;
                        if (cfg_mode)
                        begin
                            cfg_armed <= 1'b1;
                        end
                    end
                end
                LOAD:
                begin
                    bit_cnt <= BIT_LAST;  // msb first
                    state   <= SYNC;
                end
                SYNC:
                begin
                    sync_int <= 1'b0;
                    state    <= SHIFT;
                end
                SHIFT:
                begin
                    // last bit is on the lines, close the frame so the
                    // next falling edge sees sync high
                    if (bit_cnt == '0)
                    begin
                        sync_int <= 1'b1;
                        state    <= DONE;
                    end
                    else
                    begin
                        bit_cnt <= bit_cnt - 1'b1;
                    end
                end
                DONE:
                begin
                    state <= IDLE;  // sync stays high for a full period
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // shadow buffers hold what is being and was last sent
    always_ff @(posedge PMD_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < `NUM_DAC; i++)
            begin
                shadow_word[i] <= '0;
            end
        end
        else if (fall_stb && (state == LOAD))
        begin
            for (int i = 0; i < `NUM_DAC; i++)
            begin
                shadow_word[i] <= hold_word[i];
            end
        end
    end

    //////////////////////////////////////////////////
    // bus registers, updated on rising sclk
    //////////////////////////////////////////////////

    always_ff @(posedge PMD_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            sync_n <= 1'b1;
            sdin   <= '0;
        end
        else if (rise_stb)
        begin
            sync_n <= sync_int;
            for (int i = 0; i < `NUM_DAC; i++)
            begin
                sdin[i] <= shadow_word[i][bit_cnt];  // all lines in parallel
            end
        end
    end

    assign ready = (state == IDLE);

endmodule

// ==== verilog/word_latch.sv ====
`include "dac_cfg.svh"

module word_latch
    import dac_pkg::*;
(
    input  logic                 PMD_clk,
    input  logic                 arst_n,

    // stream side, one word per channel
    input  stream_word_t         ch_data [`NUM_DAC],
    input  logic [`NUM_DAC-1:0]  ch_valid,

    // configuration side
    input  logic                 cfg_mode,
    input  stream_word_t         cfg_data,
    input  logic                 cfg_valid,
    input  chan_sel_t            cfg_chan,

    // latest command per channel
    output dac_word_t            hold_word [`NUM_DAC]
);

    dac_data_t stream_code [`NUM_DAC];  // top bits of each stream word
    dac_word_t stream_cmd  [`NUM_DAC];  // prefixed write command
    dac_word_t cfg_cmd;                 // raw configuration command

    //////////////////////////////////////////////////
    // command forming
    //////////////////////////////////////////////////

    always_comb
    begin
        for (int i = 0; i < `NUM_DAC; i++)
        begin
            // msb-aligned code, low stream bits are dropped
            stream_code[i] = ch_data[i][`STREAM_WIDTH-1 -: `DAC_DATA_WIDTH];
            stream_cmd[i]  = {`DAC_WRITE_PREFIX, stream_code[i]};
        end
    end

    // low bits taken as is, prefix supplied by the host
    assign cfg_cmd = cfg_data[`DAC_WORD_WIDTH-1:0];

    //////////////////////////////////////////////////
    // holding registers
    //////////////////////////////////////////////////

    // newest word wins, no back-pressure toward the source
    always_ff @(posedge PMD_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 0; i < `NUM_DAC; i++)
            begin
                hold_word[i] <= '0;
            end
        end
        else
        begin
            for (int i = 0; i < `NUM_DAC; i++)
            begin
                if (cfg_mode)
                begin
                    // only the addressed channel takes the word
                    if (cfg_valid && (cfg_chan == chan_sel_t'(i)))
                    begin
                        hold_word[i] <= cfg_cmd;
                    end
                end
                else if (ch_valid[i])
                begin
                    hold_word[i] <= stream_cmd[i];  // data register write
                end
            end
        end
    end

endmodule

// ==== verilog/sclk_gen.sv ====
`include "dac_cfg.svh"

module sclk_gen
(
    input  logic PMD_clk,
    input  logic arst_n,
    output logic sclk,
    output logic rise_stb,
    output logic fall_stb
);

    // counter wide enough for the half period
    localparam int CNT_W = $clog2(`SCLK_HALF_DIV + 1);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`SCLK_HALF_DIV - 1);

    logic [CNT_W-1:0] div_cnt;
    logic             half_done;

    //////////////////////////////////////////////////
    // half period divider
    //////////////////////////////////////////////////

    assign half_done = (div_cnt == CNT_LAST);  // sclk flips on this edge

    always_ff @(posedge PMD_clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            div_cnt <= '0;
            sclk    <= 1'b0;   // bus idles low
        end
        else if (half_done)
        begin
            div_cnt <= '0;
            sclk    <= ~sclk;
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // edge strobes
    //////////////////////////////////////////////////

    // strobes lead the sclk level by the register, so logic clocked on a
    // strobe updates together with the matching sclk edge
    assign rise_stb = half_done & ~sclk;  // sclk goes high next edge
    assign fall_stb = half_done &  sclk;  // sclk goes low next edge

endmodule

// ==== verilog/dac_pkg.sv ====
`include "dac_cfg.svh"

package dac_pkg;

    //////////////////////////////////////////////////
    // data words
    //////////////////////////////////////////////////

    // full 24-bit command as shifted out on a data line
    typedef logic [`DAC_WORD_WIDTH-1:0] dac_word_t;

    // dac code field inside a command
    typedef logic [`DAC_DATA_WIDTH-1:0] dac_data_t;

    // raw input word, stream or configuration
    typedef logic [`STREAM_WIDTH-1:0] stream_word_t;

    // channel index for configuration writes
    typedef logic [$clog2(`NUM_DAC)-1:0] chan_sel_t;

    //////////////////////////////////////////////////
    // frame sequencer
    //////////////////////////////////////////////////

    typedef enum logic [2:0]
    {
        IDLE,   // wait for a changed word
        LOAD,   // capture hold words, arm counter
        SYNC,   // pull frame sync low
        SHIFT,  // one bit per serial clock
        DONE    // gap before next frame
    } frame_state_t;

endpackage

// ==== verilog/dac_cfg.svh ====
`ifndef DAC_CFG_SVH
`define DAC_CFG_SVH

//////////////////////////////////////////////////
// channel count and word widths
//////////////////////////////////////////////////

`define NUM_DAC          4        // dac channels, one data line each
`define DAC_DATA_WIDTH   20       // dac code width
`define DAC_WORD_WIDTH   24       // serial command length
`define STREAM_WIDTH     32       // input word width

//////////////////////////////////////////////////
// serial clock and command encoding
//////////////////////////////////////////////////

`define SCLK_HALF_DIV    5        // PMD_clk cycles per sclk half period
`define DAC_WRITE_PREFIX 4'b0001  // data register write

`endif
